//--- hdl/mips_isa_pkg.sv
package mips_isa_pkg;

   ////////////////////////////////////////
   // Opcodes and funct codes
   ////////////////////////////////////////

   localparam logic [5:0] OP_SPECIAL = 6'b000000;   // R-type, decoded by funct
   localparam logic [5:0] OP_J       = 6'b000010;
   localparam logic [5:0] OP_JAL     = 6'b000011;
   localparam logic [5:0] OP_BEQ     = 6'b000100;
   localparam logic [5:0] OP_BNE     = 6'b000101;

   localparam logic [5:0] FN_JR      = 6'b001000;
   localparam logic [5:0] FN_JALR    = 6'b001001;

   // Return address register for JAL
   localparam logic [4:0] LINK_REG   = 5'd31;

   ////////////////////////////////////////
   // Instruction formats
   ////////////////////////////////////////

   typedef struct packed
   {
      logic [5:0] op;
      logic [4:0] rs;
      logic [4:0] rt;
      logic [4:0] rd;
      logic [4:0] shamt;
      logic [5:0] funct;
   } r_fmt_t;

   typedef struct packed
   {
      logic [5:0]  op;
      logic [4:0]  rs;
      logic [4:0]  rt;
      logic [15:0] imm;   // Branch offset in words
   } i_fmt_t;

   typedef struct packed
   {
      logic [5:0]  op;
      logic [25:0] index;
   } j_fmt_t;

   // One instruction word, three ways to look at it
   typedef union packed
   {
      r_fmt_t r;
      i_fmt_t i;
      j_fmt_t j;
   } instr_t;

   // Branch flag, numbering kept from the old pipeline
   typedef enum logic [2:0]
   {
      BR_NONE = 3'd0,
      BR_JR   = 3'd1,
      BR_JALR = 3'd2,
      BR_BEQ  = 3'd3,
      BR_BNE  = 3'd4,
      BR_J    = 3'd5,
      BR_JAL  = 3'd6
   } branch_flag_t;

endpackage

//--- hdl/branch_pipe_pkg.sv
package branch_pipe_pkg;

   localparam int ADDR_BITS = 11;   // Word address width
   localparam int DATA_BITS = 32;

   typedef logic [ADDR_BITS-1:0] addr_t;
   typedef logic [DATA_BITS-1:0] data_t;

   ////////////////////////////////////////
   // Stage interfaces
   ////////////////////////////////////////

   // Decode stage output as seen by this stage
   typedef struct packed
   {
      logic                 valid;
      addr_t                pc;
      mips_isa_pkg::instr_t instr;
      data_t                rs_val;
      data_t                rt_val;
   } stage_in_t;

   typedef struct packed
   {
      mips_isa_pkg::branch_flag_t flag;
      logic [25:0]                index;    // J-type target
      logic [15:0]                offset;   // BEQ/BNE displacement
      logic [4:0]                 rd;       // JALR link register
      addr_t                      pc;
      data_t                      rs_val;
      data_t                      rt_val;
   } decoded_t;

   // Result of one resolution path
   typedef struct packed
   {
      logic  take;
      addr_t target;
   } target_t;

   typedef struct packed
   {
      logic  valid;
      logic  taken;
      addr_t target;
      logic  hazard_disable;   // Hazard unit skips its stall check
   } redirect_t;

   typedef struct packed
   {
      logic       write;
      logic [4:0] reg_num;
      addr_t      value;   // Return address, PC plus one
   } link_t;

endpackage

//--- hdl/branch_flag_decoder.sv
module branch_flag_decoder
(
   input  branch_pipe_pkg::stage_in_t i_stage,
   output branch_pipe_pkg::decoded_t  o_dec
);

   mips_isa_pkg::instr_t       instr;
   mips_isa_pkg::branch_flag_t flag;

   assign instr = i_stage.instr;

   ////////////////////////////////////////
   // Flag decode
   ////////////////////////////////////////

   always_comb
   begin
      flag = mips_isa_pkg::BR_NONE;
      case (instr.r.op)
         mips_isa_pkg::OP_SPECIAL:
         begin
            // Only the two register jumps matter here
            if (instr.r.funct == mips_isa_pkg::FN_JR)
            begin
               flag = mips_isa_pkg::BR_JR;
            end
            else if (instr.r.funct == mips_isa_pkg::FN_JALR)
            begin
               flag = mips_isa_pkg::BR_JALR;
            end
         end
         mips_isa_pkg::OP_J:   flag = mips_isa_pkg::BR_J;
         mips_isa_pkg::OP_JAL: flag = mips_isa_pkg::BR_JAL;
         mips_isa_pkg::OP_BEQ: flag = mips_isa_pkg::BR_BEQ;
         mips_isa_pkg::OP_BNE: flag = mips_isa_pkg::BR_BNE;
         default:              flag = mips_isa_pkg::BR_NONE;
      endcase
   end

   ////////////////////////////////////////
   // Field pass-through
   ////////////////////////////////////////

   always_comb
   begin
      o_dec.flag   = flag;
      o_dec.index  = instr.j.index;   // J view
      o_dec.offset = instr.i.imm;     // I view
      o_dec.rd     = instr.r.rd;      // R view, JALR destination
      o_dec.pc     = i_stage.pc;
      o_dec.rs_val = i_stage.rs_val;
      o_dec.rt_val = i_stage.rt_val;
   end

endmodule

//--- hdl/branch_address_calculator.sv
module branch_address_calculator
(
   input  branch_pipe_pkg::decoded_t i_dec,
   output branch_pipe_pkg::target_t  o_jump,
   output logic                      o_hazard_disable
);

   branch_pipe_pkg::addr_t index_target;
   branch_pipe_pkg::addr_t reg_target;

   // Low index bits only, PC upper bits not concatenated
   assign index_target = i_dec.index[branch_pipe_pkg::ADDR_BITS-1:0];
   assign reg_target   = i_dec.rs_val[branch_pipe_pkg::ADDR_BITS-1:0];

   ////////////////////////////////////////
   // Unconditional jumps
   ////////////////////////////////////////

   always_comb
   begin
      o_jump.take      = 1'b0;
      o_jump.target    = '0;
      o_hazard_disable = 1'b0;

      case (i_dec.flag)
         mips_isa_pkg::BR_JR,
         mips_isa_pkg::BR_JALR:
         begin
            // Target from rs operand
            o_jump.take   = 1'b1;
            o_jump.target = reg_target;
         end

         mips_isa_pkg::BR_J,
         mips_isa_pkg::BR_JAL:
         begin
            o_jump.take      = 1'b1;
            o_jump.target    = index_target;
            o_hazard_disable = 1'b1;   // No register read, nothing to stall on
         end

         // BEQ, BNE and none handled elsewhere
         default:
         begin
            o_jump.take      = 1'b0;
            o_jump.target    = '0;
            o_hazard_disable = 1'b0;
         end
      endcase
   end

endmodule

//--- hdl/branch_condition_unit.sv
module branch_condition_unit
(
   input  branch_pipe_pkg::decoded_t i_dec,
   output branch_pipe_pkg::target_t  o_cond
);

   branch_pipe_pkg::data_t offset_ext;
   branch_pipe_pkg::addr_t rel_target;
   logic                   operands_equal;

   ////////////////////////////////////////
   // PC-relative target
   ////////////////////////////////////////

   // Sign extend the 16-bit word offset
   assign offset_ext = {{(branch_pipe_pkg::DATA_BITS-16){i_dec.offset[15]}}, i_dec.offset};

   // Wraps modulo the address space
   assign rel_target = i_dec.pc
                     + branch_pipe_pkg::addr_t'(1)
                     + branch_pipe_pkg::addr_t'(offset_ext);

   assign operands_equal = (i_dec.rs_val == i_dec.rt_val);

   ////////////////////////////////////////
   // Condition evaluation
   ////////////////////////////////////////

   always_comb
   begin
      o_cond.take   = 1'b0;
      o_cond.target = '0;

      case (i_dec.flag)
         mips_isa_pkg::BR_BEQ:
         begin
            o_cond.take   = operands_equal;
            o_cond.target = rel_target;
         end

         mips_isa_pkg::BR_BNE:
         begin
            o_cond.take   = !operands_equal;
            o_cond.target = rel_target;
         end

         default:
         begin
            // Jumps and non-branches
            o_cond.take   = 1'b0;
            o_cond.target = '0;
         end
      endcase
   end

endmodule

//--- hdl/branch_redirect_unit.sv
module branch_redirect_unit
(
   input  logic                      i_clock,
   input  logic                      i_rst_n,
   input  logic                      i_stage_enable,
   input  logic                      i_valid,
   input  branch_pipe_pkg::decoded_t i_dec,
   input  branch_pipe_pkg::target_t  i_jump,
   input  branch_pipe_pkg::target_t  i_cond,
   input  logic                      i_hazard_disable,
   output branch_pipe_pkg::redirect_t o_redirect,
   output branch_pipe_pkg::link_t     o_link
);

   logic                   take;
   branch_pipe_pkg::addr_t target;
   logic                   link_write;
   logic [4:0]             link_reg;
   branch_pipe_pkg::addr_t return_addr;

   // Control registers
   logic valid_q;
   logic taken_q;
   logic hazard_q;
   logic write_q;

   // Payload registers
   branch_pipe_pkg::addr_t target_q;
   logic [4:0]             reg_num_q;
   branch_pipe_pkg::addr_t value_q;

   ////////////////////////////////////////
   // Merge
   ////////////////////////////////////////

   assign take   = i_jump.take | i_cond.take;   // At most one fires
   assign target = i_jump.take ? i_jump.target : i_cond.target;

   assign link_write  = (i_dec.flag == mips_isa_pkg::BR_JAL)
                     || (i_dec.flag == mips_isa_pkg::BR_JALR);
   assign link_reg    = (i_dec.flag == mips_isa_pkg::BR_JAL) ? mips_isa_pkg::LINK_REG
                                                              : i_dec.rd;
   assign return_addr = i_dec.pc + branch_pipe_pkg::addr_t'(1);

   ////////////////////////////////////////
   // Output registers
   ////////////////////////////////////////

   always_ff @(posedge i_clock)
   begin
      if (!i_rst_n)
      begin
         valid_q  <= 1'b0;
         taken_q  <= 1'b0;
         hazard_q <= 1'b0;
         write_q  <= 1'b0;
      end
      else if (i_stage_enable)   // Hold on stall
      begin
         valid_q  <= i_valid;
         taken_q  <= i_valid & take;
         hazard_q <= i_valid & i_hazard_disable;
         write_q  <= i_valid & link_write;
      end
   end

   always_ff @(posedge i_clock)
   begin
      if (i_stage_enable)
      begin
         target_q  <= target;
         reg_num_q <= link_reg;
         value_q   <= return_addr;
      end
   end

   assign o_redirect = '{valid: valid_q, taken: taken_q, target: target_q,
                         hazard_disable: hazard_q};
   assign o_link     = '{write: write_q, reg_num: reg_num_q, value: value_q};

endmodule

//--- hdl/branch_resolve_top.sv
module branch_resolve_top
(
   input  logic                       i_clock,
   input  logic                       i_rst_n,
   input  logic                       i_stage_enable,
   input  branch_pipe_pkg::stage_in_t i_stage,
   output branch_pipe_pkg::redirect_t o_redirect,   // To fetch and hazard unit
   output branch_pipe_pkg::link_t     o_link        // To writeback
);

   branch_pipe_pkg::decoded_t dec;
   branch_pipe_pkg::target_t  jump_res;
   branch_pipe_pkg::target_t  cond_res;
   logic                      hazard_disable;

   ////////////////////////////////////////
   // Combinational resolution
   ////////////////////////////////////////

   branch_flag_decoder branch_flag_decoder_i
   (
      .i_stage (i_stage),
      .o_dec   (dec)
   );

   // Jump and branch paths side by side
   branch_address_calculator branch_address_calculator_i
   (
      .i_dec            (dec),
      .o_jump           (jump_res),
      .o_hazard_disable (hazard_disable)
   );

   branch_condition_unit branch_condition_unit_i
   (
      .i_dec  (dec),
      .o_cond (cond_res)
   );

   // Registered outputs, one cycle latency
   branch_redirect_unit branch_redirect_unit_i
   (
      .i_clock          (i_clock),
      .i_rst_n          (i_rst_n),
      .i_stage_enable   (i_stage_enable),
      .i_valid          (i_stage.valid),
      .i_dec            (dec),
      .i_jump           (jump_res),
      .i_cond           (cond_res),
      .i_hazard_disable (hazard_disable),
      .o_redirect       (o_redirect),
      .o_link           (o_link)
   );

endmodule

//--- bench/branch_checker.sv
module branch_checker
(
   input  logic                       i_clock,
   input  logic                       i_rst_n,
   input  logic                       i_stage_enable,
   input  branch_pipe_pkg::stage_in_t i_stage,
   input  branch_pipe_pkg::redirect_t i_redirect,
   input  branch_pipe_pkg::link_t     i_link,
   output int                         o_errors,
   output int                         o_checks
);

   branch_pipe_pkg::redirect_t exp_redirect;
   branch_pipe_pkg::link_t     exp_link;
   logic                       exp_known = 1'b0;   // Set by the first edge in reset

   initial
   begin
      o_errors = 0;
      o_checks = 0;
   end

   ////////////////////////////////////////
   // Reference model
   ////////////////////////////////////////

   function automatic void expect_branch
   (
      input  branch_pipe_pkg::stage_in_t s,
      output branch_pipe_pkg::redirect_t r,
      output branch_pipe_pkg::link_t     l
   );
      logic [5:0]  op;
      logic [5:0]  funct;
      logic [10:0] pc_next;
      int          offset;
      int          rel_sum;
      op      = s.instr[31:26];
      funct   = s.instr[5:0];
      pc_next = s.pc + 11'd1;
      offset  = int'($signed(s.instr[15:0]));
      rel_sum = int'(s.pc) + 1 + offset;   // Low bits give the result modulo 2048
      r       = '0;
      l       = '0;
      r.valid = s.valid;
      if (s.valid)
      begin
         case (op)
            mips_isa_pkg::OP_J,
            mips_isa_pkg::OP_JAL:
            begin
               r.taken          = 1'b1;
               r.target         = s.instr[10:0];
               r.hazard_disable = 1'b1;
               l.write          = (op == mips_isa_pkg::OP_JAL);
               l.reg_num        = 5'd31;
               l.value          = pc_next;
            end
            mips_isa_pkg::OP_SPECIAL:
            begin
               if (funct == mips_isa_pkg::FN_JR || funct == mips_isa_pkg::FN_JALR)
               begin
                  r.taken  = 1'b1;
                  r.target = s.rs_val[10:0];
                  l.write  = (funct == mips_isa_pkg::FN_JALR);
                  l.reg_num = s.instr[15:11];   // rd field
                  l.value  = pc_next;
               end
            end
            mips_isa_pkg::OP_BEQ:
            begin
               r.taken  = (s.rs_val == s.rt_val);
               r.target = rel_sum[10:0];
            end
            mips_isa_pkg::OP_BNE:
            begin
               r.taken  = (s.rs_val != s.rt_val);
               r.target = rel_sum[10:0];
            end
            default:
            begin
               r.taken = 1'b0;
            end
         endcase
      end
   endfunction

   ////////////////////////////////////////
   // Sample and compare
   ////////////////////////////////////////

   always @(posedge i_clock)
   begin
      if (!i_rst_n)
      begin
         exp_redirect = '0;
         exp_link     = '0;
         exp_known    = 1'b1;
      end
      else if (i_stage_enable)
      begin
         expect_branch(i_stage, exp_redirect, exp_link);
      end
      // Stall keeps the previous expectation
   end

   task automatic check_field(input string name, input logic [31:0] got, input logic [31:0] want);
      o_checks++;
      if (got !== want)
      begin
         o_errors++;
         $display("[ERROR] %s: got 0x%h, expected 0x%h at %0t", name, got, want, $time);
      end
   endtask

   // Outputs are settled half a cycle after the edge
   always @(negedge i_clock)
   begin
      if (exp_known)
      begin
         check_field("o_redirect.valid", 32'(i_redirect.valid), 32'(exp_redirect.valid));
         check_field("o_redirect.taken", 32'(i_redirect.taken), 32'(exp_redirect.taken));
         check_field("o_redirect.hazard_disable", 32'(i_redirect.hazard_disable),
                     32'(exp_redirect.hazard_disable));
         check_field("o_link.write", 32'(i_link.write), 32'(exp_link.write));
         if (exp_redirect.taken)
            check_field("o_redirect.target", 32'(i_redirect.target), 32'(exp_redirect.target));
         if (exp_link.write)
         begin
            check_field("o_link.reg_num", 32'(i_link.reg_num), 32'(exp_link.reg_num));
            check_field("o_link.value", 32'(i_link.value), 32'(exp_link.value));
         end
      end
   end

endmodule

//--- bench/tb_branch_resolve.sv
module tb_branch_resolve;

   localparam int WAIT_LIMIT = 20;   // Cycles per wait loop

   logic                       clock = 1'b0;
   logic                       rst_n;
   logic                       stage_enable;
   branch_pipe_pkg::stage_in_t stage;
   branch_pipe_pkg::redirect_t redirect;
   branch_pipe_pkg::link_t     link_wr;

   logic [15:0] lfsr_state   = 16'd65308;
   logic        timed_out    = 1'b0;
   int          tests_passed = 0;
   int          tests_failed = 0;
   int          errors;
   int          checks;

   branch_resolve_top branch_resolve_top_i
   (
      .i_clock        (clock),
      .i_rst_n        (rst_n),
      .i_stage_enable (stage_enable),
      .i_stage        (stage),
      .o_redirect     (redirect),
      .o_link         (link_wr)
   );

   branch_checker branch_checker_i
   (
      .i_clock        (clock),
      .i_rst_n        (rst_n),
      .i_stage_enable (stage_enable),
      .i_stage        (stage),
      .i_redirect     (redirect),
      .i_link         (link_wr),
      .o_errors       (errors),
      .o_checks       (checks)
   );

   always #50 clock = ~clock;

   initial
   begin
      rst_n = 1'b0;
      repeat (3) @(posedge clock);
      rst_n <= 1'b1;
   end

   ////////////////////////////////////////
   // Random fields
   ////////////////////////////////////////

   // Taps 16, 14, 13, 11
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   task automatic random_bits(input int n, output logic [31:0] v);
      v = '0;
      for (int k = 0; k < n; k++)
      begin
         lfsr_state = lfsr_next(lfsr_state);
         v = {v[30:0], lfsr_state[0]};
      end
   endtask

   task automatic build_instr(input mips_isa_pkg::branch_flag_t kind, output logic [31:0] word);
      logic [31:0] r;
      logic [31:0] pick;
      random_bits(26, r);
      case (kind)
         mips_isa_pkg::BR_J:    word = {mips_isa_pkg::OP_J, r[25:0]};
         mips_isa_pkg::BR_JAL:  word = {mips_isa_pkg::OP_JAL, r[25:0]};
         mips_isa_pkg::BR_JR:   word = {mips_isa_pkg::OP_SPECIAL, r[25:6], mips_isa_pkg::FN_JR};
         mips_isa_pkg::BR_JALR: word = {mips_isa_pkg::OP_SPECIAL, r[25:6], mips_isa_pkg::FN_JALR};
         mips_isa_pkg::BR_BEQ:  word = {mips_isa_pkg::OP_BEQ, r[25:0]};
         mips_isa_pkg::BR_BNE:  word = {mips_isa_pkg::OP_BNE, r[25:0]};
         default:
         begin
            random_bits(7, pick);
            word = {pick[5:0], r[25:0]};
            if (pick[6])
               word[31:26] = mips_isa_pkg::OP_SPECIAL;   // Other funct codes
            if (word[31:26] inside {mips_isa_pkg::OP_J, mips_isa_pkg::OP_JAL,
                                    mips_isa_pkg::OP_BEQ, mips_isa_pkg::OP_BNE})
               word[31:26] ^= 6'h10;
            if (word[31:26] == mips_isa_pkg::OP_SPECIAL
                && word[5:0] inside {mips_isa_pkg::FN_JR, mips_isa_pkg::FN_JALR})
               word[5:0] ^= 6'h20;
         end
      endcase
   endtask

   task automatic drive_instr(input mips_isa_pkg::branch_flag_t kind, input logic force_eq,
                              input logic valid);
      logic [31:0] word;
      logic [31:0] pc_bits;
      logic [31:0] rs;
      logic [31:0] rt;
      build_instr(kind, word);
      random_bits(11, pc_bits);
      random_bits(32, rs);
      random_bits(32, rt);
      if (force_eq)
         rt = rs;
      stage <= {valid, pc_bits[10:0], word, rs, rt};
   endtask

   ////////////////////////////////////////
   // Waits and reporting
   ////////////////////////////////////////

   task automatic wait_result(input string what);
      int  n;
      logic seen;
      n    = 0;
      seen = 1'b0;
      while (!seen && n < WAIT_LIMIT && !timed_out)
      begin
         @(negedge clock);
         seen = (redirect.valid === 1'b1);
         n++;
      end
      if (!seen && !timed_out)
      begin
         $display("Timeout: no valid result within %0d cycles during %s", WAIT_LIMIT, what);
         timed_out = 1'b1;
      end
   endtask

   task automatic wait_reset();
      int n;
      n = 0;
      while (rst_n !== 1'b1 && n < WAIT_LIMIT)
      begin
         @(posedge clock);
         n++;
      end
      if (rst_n !== 1'b1)
      begin
         $display("Timeout: reset was never released");
         timed_out = 1'b1;
      end
   endtask

   task automatic report_test(input string name, input int e0, input int c0);
      int e;
      int c;
      @(posedge clock);   // Let the last compare land
      e = errors - e0;
      c = checks - c0;
      if (e == 0 && c > 0 && !timed_out)
      begin
         tests_passed++;
         $display("test %-12s ok, %0d checks", name, c);
      end
      else
      begin
         tests_failed++;
         $display("test %-12s failed, %0d errors in %0d checks", name, e, c);
      end
   endtask

   task automatic send_one(input mips_isa_pkg::branch_flag_t kind, input logic force_eq,
                           input string name);
      @(posedge clock);
      drive_instr(kind, force_eq, 1'b1);
      @(posedge clock);
      stage.valid <= 1'b0;
      wait_result(name);
   endtask

   task automatic kind_test(input string name, input mips_isa_pkg::branch_flag_t kind,
                            input logic force_eq);
      int e0;
      int c0;
      e0 = errors;
      c0 = checks;
      for (int n = 0; n < 8 && !timed_out; n++)
         send_one(kind, force_eq, name);
      report_test(name, e0, c0);
   endtask

   ////////////////////////////////////////
   // Test sequence
   ////////////////////////////////////////

   initial
   begin
      int          e0;
      int          c0;
      logic [31:0] v;
      stage_enable = 1'b0;
      stage        = '0;
      wait_reset();
      e0 = errors;
      c0 = checks;
      @(posedge clock);
      stage_enable <= 1'b1;
      repeat (4) @(posedge clock);   // Idle, nothing valid yet
      report_test("reset_idle", e0, c0);

      if (!timed_out) kind_test("jump_j", mips_isa_pkg::BR_J, 1'b0);
      if (!timed_out) kind_test("jump_jal", mips_isa_pkg::BR_JAL, 1'b0);
      if (!timed_out) kind_test("reg_jr", mips_isa_pkg::BR_JR, 1'b0);
      if (!timed_out) kind_test("reg_jalr", mips_isa_pkg::BR_JALR, 1'b0);
      if (!timed_out) kind_test("beq_random", mips_isa_pkg::BR_BEQ, 1'b0);
      if (!timed_out) kind_test("bne_random", mips_isa_pkg::BR_BNE, 1'b0);
      if (!timed_out) kind_test("beq_equal", mips_isa_pkg::BR_BEQ, 1'b1);
      if (!timed_out) kind_test("bne_equal", mips_isa_pkg::BR_BNE, 1'b1);

      // Non-branches back to back with random valid
      if (!timed_out)
      begin
         e0 = errors;
         c0 = checks;
         for (int n = 0; n < 24; n++)
         begin
            @(posedge clock);
            random_bits(1, v);
            drive_instr(mips_isa_pkg::BR_NONE, 1'b0, v[0]);
         end
         send_one(mips_isa_pkg::BR_NONE, 1'b0, "non_branch");
         report_test("non_branch", e0, c0);
      end

      // Stall between two instructions
      if (!timed_out)
      begin
         e0 = errors;
         c0 = checks;
         for (int n = 0; n < 4 && !timed_out; n++)
         begin
            @(posedge clock);
            drive_instr(mips_isa_pkg::BR_JAL, 1'b0, 1'b1);
            @(posedge clock);
            if (n % 2 == 0)
               drive_instr(mips_isa_pkg::BR_BEQ, 1'b1, 1'b1);
            else
               drive_instr(mips_isa_pkg::BR_JR, 1'b0, 1'b1);
            stage_enable <= 1'b0;
            repeat (3 + n) @(posedge clock);
            stage_enable <= 1'b1;
            @(posedge clock);
            stage.valid <= 1'b0;
            wait_result("stall");
         end
         report_test("stall", e0, c0);
      end

      $display("Tests passed: %0d, failed: %0d, value errors: %0d",
               tests_passed, tests_failed, errors);
      if (timed_out || tests_failed != 0 || errors != 0)
         $display("TEST FAIL");
      else
         $display("TEST PASS");
      $finish;
   end

endmodule

//--- project.f
hdl/mips_isa_pkg.sv
hdl/branch_pipe_pkg.sv
hdl/branch_flag_decoder.sv
hdl/branch_address_calculator.sv
hdl/branch_condition_unit.sv
hdl/branch_redirect_unit.sv
hdl/branch_resolve_top.sv
bench/branch_checker.sv
bench/tb_branch_resolve.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the branch resolution testbench with Verilator, run it, and check the log

cd "$(dirname "$0")" \
   && verilator --binary --timing -j 0 --top-module tb_branch_resolve \
      -f project.f -o sim_branch_resolve > build.log 2>&1 \
   || { echo "Verilator build failed, see build.log"; exit 1; }

./obj_dir/sim_branch_resolve > sim.log 2>&1 \
   || { echo "Simulation exited with an error, see sim.log"; exit 1; }

grep -qx "TEST PASS" sim.log \
   && echo "Simulation passed" \
   || { echo "Simulation failed, see sim.log"; exit 1; }
